// ==== hw/adc_acq_pkg.sv ====
`default_nettype none

package adc_acq_pkg;

    // enables and trigger cross into the adc clock through this many flops
    localparam int ENABLE_SYNC_STAGES = 4;
    // ddr3 writer done flag comes from a slower domain, two flops suffice
    localparam int DONE_SYNC_STAGES = 2;
    localparam int FILL_TYPE_W = 2;
    localparam int STATE_W = 5;

    // {enable1, enable0}, selects the burst count used downstream
    typedef logic [FILL_TYPE_W-1:0] fill_type_t;

    // sequencer states, one entry per step of a fill
    typedef enum logic [STATE_W-1:0] {
        IDLE,
        WATCH_FOR_TRIG,
        FILL_INIT1,
        FILL_INIT2,
        WAVEFORM_INIT1,
        WAVEFORM_INIT2,
        WAVEFORM_INIT3,
        RUN1,
        RUN2,
        RUN3,
        RUN4,
        WAVEFORM_TST1,
        WAVEFORM_TST2,
        CHECKSUM1,
        CHECKSUM2,
        DDR3_WAIT,
        DONE
    } acq_state_e;

    // synchronized and decoded inputs
    typedef struct packed {
        logic       mode_enabled;
        // fourth trigger stage, used to hold DONE
        logic       trig_level;
        logic       trig_pulse;
        fill_type_t fill_type;
        logic       ddr3_wr_done;
    } acq_sync_t;

    // output mux selects and checksum control
    typedef struct packed {
        logic fill_hdr_sel;
        logic wfm_hdr_sel;
        logic dat_sel;
        logic checksum_select;
        logic checksum_update;
    } acq_mux_sel_t;

    // circular buffer read side
    typedef struct packed {
        logic init_rd_addr;
        logic inc_rd_addr;
        logic latch_dat;
        logic trig_addr_rd_en;
    } acq_cbuf_ctrl_t;

    // external address, burst and fill counters
    typedef struct packed {
        logic address_cntr_en;
        logic burst_cntr_init;
        logic burst_cntr_en;
        logic fill_cntr_en;
        logic dummy_dat_reset;
    } acq_cntr_ctrl_t;

    typedef struct packed {
        logic sm_idle;
        // high while writing to ddr3, low while reads are allowed
        logic acq_enabled;
        logic acq_done;
    } acq_status_t;

endpackage

`default_nettype wire

// ==== hw/acq_input_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module acq_input_sync (
    input  wire logic                  clk,
    input  wire logic                  adc_acq_full_reset,
    input  wire logic                  acq_enable0,
    input  wire logic                  acq_enable1,
    input  wire logic                  acq_trig,
    input  wire logic                  ddr3_wr_done,
    output adc_acq_pkg::acq_sync_t     sync
);

    // stage chain for {trig, enable1, enable0}, index 0 is the first flop
    logic [adc_acq_pkg::ENABLE_SYNC_STAGES-1:0][2:0] in_sync;
    // extra trigger stage for edge detection
    logic                                            trig_dly;
    logic [adc_acq_pkg::DONE_SYNC_STAGES-1:0]        done_sync;

    logic                   trig_last;
    logic                   en0_last;
    logic                   en1_last;
    logic                   mode_enabled;
    logic                   trig_pulse;
    adc_acq_pkg::fill_type_t fill_type;

    // outputs of the last synchronizer stage
    assign trig_last = in_sync[adc_acq_pkg::ENABLE_SYNC_STAGES-1][2];
    assign en1_last  = in_sync[adc_acq_pkg::ENABLE_SYNC_STAGES-1][1];
    assign en0_last  = in_sync[adc_acq_pkg::ENABLE_SYNC_STAGES-1][0];

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            in_sync   <= '0;
            trig_dly  <= 1'b0;
            done_sync <= '0;
        end else begin
            // shift the raw bits in at stage 0
            in_sync   <= {in_sync[adc_acq_pkg::ENABLE_SYNC_STAGES-2:0],
                          {acq_trig, acq_enable1, acq_enable0}};
            trig_dly  <= trig_last;
            done_sync <= {done_sync[adc_acq_pkg::DONE_SYNC_STAGES-2:0], ddr3_wr_done};
        end
    end

    // mode, fill type and trigger pulse land one cycle after the last stage
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            mode_enabled <= 1'b0;
            fill_type    <= '0;
            trig_pulse   <= 1'b0;
        end else begin
            // any nonzero enable pattern arms the channel
            mode_enabled <= en0_last | en1_last;
            fill_type    <= {en1_last, en0_last};
            // rising edge at stage four, passed only while armed
            trig_pulse   <= trig_last & ~trig_dly & mode_enabled;
        end
    end

    always_comb begin
        sync.mode_enabled = mode_enabled;
        sync.trig_level   = trig_last;
        sync.trig_pulse   = trig_pulse;
        sync.fill_type    = fill_type;
        sync.ddr3_wr_done = done_sync[adc_acq_pkg::DONE_SYNC_STAGES-1];
    end

endmodule

`default_nettype wire

// ==== hw/acq_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module acq_fsm (
    input  wire logic                   clk,
    input  wire logic                   adc_acq_full_reset,
    input  wire adc_acq_pkg::acq_sync_t sync,
    input  wire logic                   trig_fifo_empty,
    input  wire logic                   burst_cntr_zero,
    output adc_acq_pkg::acq_state_e     next_state
);

    adc_acq_pkg::acq_state_e state;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            state <= adc_acq_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        // hold by default
        next_state = state;
        case (state)
            // wait until one of the enables arms the channel
            adc_acq_pkg::IDLE: begin
                if (sync.mode_enabled) begin
                    next_state = adc_acq_pkg::WATCH_FOR_TRIG;
                end
            end
            // ddr3 may be read here, leave once a trigger address is queued
            adc_acq_pkg::WATCH_FOR_TRIG: begin
                if (!trig_fifo_empty) begin
                    next_state = adc_acq_pkg::FILL_INIT1;
                end
            end
            // fill header, once per trigger
            adc_acq_pkg::FILL_INIT1: begin
                next_state = adc_acq_pkg::FILL_INIT2;
            end
            adc_acq_pkg::FILL_INIT2: begin
                next_state = adc_acq_pkg::WAVEFORM_INIT1;
            end
            // waveform header and read pointer setup
            adc_acq_pkg::WAVEFORM_INIT1: begin
                next_state = adc_acq_pkg::WAVEFORM_INIT2;
            end
            adc_acq_pkg::WAVEFORM_INIT2: begin
                next_state = adc_acq_pkg::WAVEFORM_INIT3;
            end
            adc_acq_pkg::WAVEFORM_INIT3: begin
                next_state = adc_acq_pkg::RUN1;
            end
            // four buffer words per burst
            adc_acq_pkg::RUN1: begin
                next_state = adc_acq_pkg::RUN2;
            end
            adc_acq_pkg::RUN2: begin
                next_state = adc_acq_pkg::RUN3;
            end
            adc_acq_pkg::RUN3: begin
                next_state = adc_acq_pkg::RUN4;
            end
            // loop until the external burst counter runs out
            adc_acq_pkg::RUN4: begin
                if (burst_cntr_zero) begin
                    next_state = adc_acq_pkg::WAVEFORM_TST1;
                end else begin
                    next_state = adc_acq_pkg::RUN1;
                end
            end
            // two cycles to drain the buffer read latency
            adc_acq_pkg::WAVEFORM_TST1: begin
                next_state = adc_acq_pkg::WAVEFORM_TST2;
            end
            adc_acq_pkg::WAVEFORM_TST2: begin
                next_state = adc_acq_pkg::CHECKSUM1;
            end
            adc_acq_pkg::CHECKSUM1: begin
                next_state = adc_acq_pkg::CHECKSUM2;
            end
            adc_acq_pkg::CHECKSUM2: begin
                next_state = adc_acq_pkg::DDR3_WAIT;
            end
            // the writer has to flush everything to ddr3
            adc_acq_pkg::DDR3_WAIT: begin
                if (sync.ddr3_wr_done) begin
                    next_state = adc_acq_pkg::DONE;
                end
            end
            // hold until trigger drops so one trigger cannot start two fills
            adc_acq_pkg::DONE: begin
                if (!(sync.mode_enabled && sync.trig_level)) begin
                    next_state = adc_acq_pkg::IDLE;
                end
            end
            default: begin
                next_state = adc_acq_pkg::IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/acq_strobe_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module acq_strobe_gen (
    input  wire logic                     clk,
    input  wire logic                     adc_acq_full_reset,
    input  wire adc_acq_pkg::acq_state_e  next_state,
    input  wire logic                     dummy_dat_reset_mode,
    output adc_acq_pkg::acq_mux_sel_t     mux_sel,
    output adc_acq_pkg::acq_cbuf_ctrl_t   cbuf_ctrl,
    output adc_acq_pkg::acq_cntr_ctrl_t   cntr_ctrl,
    output adc_acq_pkg::acq_status_t      status,
    output logic                          adc_acq_out_valid
);

    // header and checksum words are valid right away
    logic immed_valid;
    // burst words need an extra cycle for the buffer read
    logic start_dlyd_valid;
    logic dlyd_valid;

    // strobes registered from next_state so they line up with state entry
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            mux_sel.fill_hdr_sel      <= 1'b0;
            mux_sel.wfm_hdr_sel       <= 1'b0;
            mux_sel.dat_sel           <= 1'b0;
            mux_sel.checksum_select   <= 1'b0;
            cbuf_ctrl                 <= '0;
            cntr_ctrl                 <= '0;
            status.sm_idle            <= 1'b1;
            status.acq_done           <= 1'b0;
            immed_valid               <= 1'b0;
            start_dlyd_valid          <= 1'b0;
        end else begin
            // every strobe drops unless the coming state owns it
            mux_sel.fill_hdr_sel      <= 1'b0;
            mux_sel.wfm_hdr_sel       <= 1'b0;
            mux_sel.dat_sel           <= 1'b0;
            mux_sel.checksum_select   <= 1'b0;
            cbuf_ctrl                 <= '0;
            cntr_ctrl                 <= '0;
            status.sm_idle            <= 1'b0;
            status.acq_done           <= 1'b0;
            immed_valid               <= 1'b0;
            start_dlyd_valid          <= 1'b0;
            case (next_state)
                adc_acq_pkg::IDLE: begin
                    // front panel idle indication
                    status.sm_idle <= 1'b1;
                end
                adc_acq_pkg::FILL_INIT1: begin
                    mux_sel.fill_hdr_sel <= 1'b1;
                end
                adc_acq_pkg::FILL_INIT2: begin
                    // fill header goes out, bump the ddr3 address
                    immed_valid               <= 1'b1;
                    cntr_ctrl.address_cntr_en <= 1'b1;
                end
                adc_acq_pkg::WAVEFORM_INIT1: begin
                    // pop the trigger address, fifo is first word fall through
                    cbuf_ctrl.init_rd_addr    <= 1'b1;
                    cbuf_ctrl.trig_addr_rd_en <= 1'b1;
                    // 0 free runs the dummy data, 1 restarts it per waveform
                    cntr_ctrl.dummy_dat_reset <= dummy_dat_reset_mode;
                end
                adc_acq_pkg::WAVEFORM_INIT2: begin
                    cntr_ctrl.burst_cntr_init <= 1'b1;
                    mux_sel.wfm_hdr_sel       <= 1'b1;
                end
                adc_acq_pkg::WAVEFORM_INIT3: begin
                    // waveform header out, first buffer read issued
                    // but no latch since data is not back yet
                    immed_valid               <= 1'b1;
                    cntr_ctrl.address_cntr_en <= 1'b1;
                    cbuf_ctrl.inc_rd_addr     <= 1'b1;
                end
                adc_acq_pkg::RUN1: begin
                    cbuf_ctrl.latch_dat     <= 1'b1;
                    cbuf_ctrl.inc_rd_addr   <= 1'b1;
                    // one count per burst
                    cntr_ctrl.burst_cntr_en <= 1'b1;
                end
                adc_acq_pkg::RUN2: begin
                    cbuf_ctrl.latch_dat   <= 1'b1;
                    cbuf_ctrl.inc_rd_addr <= 1'b1;
                end
                adc_acq_pkg::RUN3: begin
                    cbuf_ctrl.latch_dat   <= 1'b1;
                    cbuf_ctrl.inc_rd_addr <= 1'b1;
                    mux_sel.dat_sel       <= 1'b1;
                end
                adc_acq_pkg::RUN4: begin
                    // burst word is written after the read latency
                    cbuf_ctrl.latch_dat       <= 1'b1;
                    cbuf_ctrl.inc_rd_addr     <= 1'b1;
                    cntr_ctrl.address_cntr_en <= 1'b1;
                    start_dlyd_valid          <= 1'b1;
                end
                adc_acq_pkg::WAVEFORM_TST1: begin
                    cbuf_ctrl.latch_dat <= 1'b1;
                end
                adc_acq_pkg::WAVEFORM_TST2: begin
                    cbuf_ctrl.latch_dat <= 1'b1;
                    mux_sel.dat_sel     <= 1'b1;
                end
                adc_acq_pkg::CHECKSUM1: begin
                    mux_sel.checksum_select <= 1'b1;
                end
                adc_acq_pkg::CHECKSUM2: begin
                    // checksum word closes the fill
                    immed_valid               <= 1'b1;
                    cntr_ctrl.address_cntr_en <= 1'b1;
                    cntr_ctrl.fill_cntr_en    <= 1'b1;
                end
                adc_acq_pkg::DONE: begin
                    status.acq_done <= 1'b1;
                end
                default: begin
                    // watch and ddr3 wait drive nothing
                end
            endcase
        end
    end

    // low while idle or watching so ddr3 reads may proceed,
    // includes the step back into IDLE
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            status.acq_enabled <= 1'b0;
        end else begin
            status.acq_enabled <= (next_state != adc_acq_pkg::IDLE) &&
                                  (next_state != adc_acq_pkg::WATCH_FOR_TRIG);
        end
    end

    // output valid and checksum update pipeline
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            dlyd_valid              <= 1'b0;
            adc_acq_out_valid       <= 1'b0;
            mux_sel.checksum_update <= 1'b0;
        end else begin
            dlyd_valid              <= start_dlyd_valid;
            adc_acq_out_valid       <= immed_valid | dlyd_valid;
            // checksum takes the burst one cycle after RUN4
            mux_sel.checksum_update <= start_dlyd_valid;
        end
    end

endmodule

`default_nettype wire

// ==== hw/adc_acq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_acq_ctrl (
    input  wire logic                   clk,
    input  wire logic                   adc_acq_full_reset,
    input  wire logic                   acq_enable0,
    input  wire logic                   acq_enable1,
    input  wire logic                   acq_trig,
    // no trigger address queued yet
    input  wire logic                   trig_fifo_empty,
    // all bursts of the waveform have been taken
    input  wire logic                   burst_cntr_zero,
    // ddr3 writer finished, still in its own clock domain
    input  wire logic                   ddr3_wr_done,
    input  wire logic                   dummy_dat_reset_mode,
    output adc_acq_pkg::fill_type_t     fill_type,
    output logic                        trig_pulse,
    output adc_acq_pkg::acq_mux_sel_t   mux_sel,
    output adc_acq_pkg::acq_cbuf_ctrl_t cbuf_ctrl,
    output adc_acq_pkg::acq_cntr_ctrl_t cntr_ctrl,
    output adc_acq_pkg::acq_status_t    status,
    output logic                        adc_acq_out_valid
);

    adc_acq_pkg::acq_sync_t  sync;
    adc_acq_pkg::acq_state_e next_state;

    // clock domain crossing and input decode
    acq_input_sync i_acq_input_sync (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .ddr3_wr_done       (ddr3_wr_done),
        .sync               (sync)
    );

    acq_fsm i_acq_fsm (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .sync               (sync),
        .trig_fifo_empty    (trig_fifo_empty),
        .burst_cntr_zero    (burst_cntr_zero),
        .next_state         (next_state)
    );

    // strobes follow next_state by one register
    acq_strobe_gen i_acq_strobe_gen (
        .clk                  (clk),
        .adc_acq_full_reset   (adc_acq_full_reset),
        .next_state           (next_state),
        .dummy_dat_reset_mode (dummy_dat_reset_mode),
        .mux_sel              (mux_sel),
        .cbuf_ctrl            (cbuf_ctrl),
        .cntr_ctrl            (cntr_ctrl),
        .status               (status),
        .adc_acq_out_valid    (adc_acq_out_valid)
    );

    // decoded inputs also go to the burst logic and trigger fifo
    assign fill_type  = sync.fill_type;
    assign trig_pulse = sync.trig_pulse;

endmodule

`default_nettype wire

// ==== verif/adc_acq_ctrl_checks.svh ====
`ifndef ADC_ACQ_CTRL_CHECKS_SVH
`define ADC_ACQ_CTRL_CHECKS_SVH

// mismatch counters, one per kind of result
int bit_errors       = 0;
int fill_type_errors = 0;
int count_errors     = 0;
// stalls and other failures without a wrong value
int other_errors     = 0;

// single control bit against its expected level
task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        bit_errors++;
        $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, expected, actual);
    end
endtask

// decoded fill type
task automatic compare_fill_type(input string name,
                                 input adc_acq_pkg::fill_type_t expected,
                                 input adc_acq_pkg::fill_type_t actual);
    if (actual !== expected) begin
        fill_type_errors++;
        $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, expected, actual);
    end
endtask

// pulse counts and latencies in cycles
task automatic compare_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
        count_errors++;
        $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
    end
endtask

task automatic note_failure(input string what);
    other_errors++;
    $display("t=%0t %s", $time, what);
endtask

function automatic int error_total();
    return bit_errors + fill_type_errors + count_errors + other_errors;
endfunction

task automatic print_error_counts();
    $display("errors: bit %0d, fill_type %0d, count %0d, other %0d",
             bit_errors, fill_type_errors, count_errors, other_errors);
endtask

`endif

// ==== verif/adc_acq_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_acq_ctrl_tb;

    localparam int CLK_PERIOD = 4;
    // fills run by the test sequence plus one slot for the mode tests
    localparam int NUM_FILLS = 8;
    localparam int TIMEOUT_NS = (NUM_FILLS + 1) * 2000 * CLK_PERIOD;
    // done flag synchronizer plus the strobe register
    localparam int DONE_LATENCY = adc_acq_pkg::DONE_SYNC_STAGES + 1;

    logic clk;
    logic adc_acq_full_reset;
    logic acq_enable0;
    logic acq_enable1;
    logic acq_trig;
    logic trig_fifo_empty;
    logic burst_cntr_zero;
    logic ddr3_wr_done;
    logic dummy_dat_reset_mode;
    adc_acq_pkg::fill_type_t     fill_type;
    logic                        trig_pulse;
    adc_acq_pkg::acq_mux_sel_t   mux_sel;
    adc_acq_pkg::acq_cbuf_ctrl_t cbuf_ctrl;
    adc_acq_pkg::acq_cntr_ctrl_t cntr_ctrl;
    adc_acq_pkg::acq_status_t    status;
    logic                        adc_acq_out_valid;

    // burst and ddr3 model state
    int n_bursts = 1;
    int burst_cnt;
    int ddr3_delay;
    // picked per fill by the test sequence
    int ddr3_wait_cycles = 5;
    // pulse counters sampled on the falling edge
    int valid_cnt;
    int addr_cnt;
    int latch_cnt;
    int inc_cnt;
    int upd_cnt;
    int trig_rd_cnt;
    int fill_cnt;
    int binit_cnt;
    int dummy_cnt;
    int pulse_cnt;
    int hdr_cnt;
    int wfm_cnt;
    int dat_cnt;
    int csel_cnt;
    int init_rd_cnt;
    int ben_cnt;
    // acq_enabled tracking
    logic track_enabled = 1'b0;
    logic in_fill = 1'b0;

    `include "adc_acq_ctrl_checks.svh"

    adc_acq_ctrl i_adc_acq_ctrl (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the sequencer is stuck", TIMEOUT_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    // external burst counter reports zero after n_bursts enables since init
    always @(posedge clk) begin
        if (adc_acq_full_reset || cntr_ctrl.burst_cntr_init) begin
            burst_cnt       <= 0;
            burst_cntr_zero <= 1'b0;
        end else if (cntr_ctrl.burst_cntr_en) begin
            burst_cnt       <= burst_cnt + 1;
            burst_cntr_zero <= (burst_cnt + 1 >= n_bursts);
        end
    end

    // ddr3 writer reports done 5 to 30 cycles into DDR3_WAIT
    always @(posedge clk) begin
        if (adc_acq_full_reset) begin
            ddr3_delay   <= 0;
            ddr3_wr_done <= 1'b0;
        end else if (cntr_ctrl.fill_cntr_en) begin
            ddr3_delay <= ddr3_wait_cycles;
        end else if (ddr3_delay == 1) begin
            ddr3_delay   <= 0;
            ddr3_wr_done <= 1'b1;
        end else if (ddr3_delay > 1) begin
            ddr3_delay <= ddr3_delay - 1;
        end else if (status.acq_done) begin
            ddr3_wr_done <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (!adc_acq_full_reset) begin
            valid_cnt   += adc_acq_out_valid;
            addr_cnt    += cntr_ctrl.address_cntr_en;
            latch_cnt   += cbuf_ctrl.latch_dat;
            inc_cnt     += cbuf_ctrl.inc_rd_addr;
            upd_cnt     += mux_sel.checksum_update;
            trig_rd_cnt += cbuf_ctrl.trig_addr_rd_en;
            fill_cnt    += cntr_ctrl.fill_cntr_en;
            binit_cnt   += cntr_ctrl.burst_cntr_init;
            dummy_cnt   += cntr_ctrl.dummy_dat_reset;
            pulse_cnt   += trig_pulse;
            hdr_cnt     += mux_sel.fill_hdr_sel;
            wfm_cnt     += mux_sel.wfm_hdr_sel;
            dat_cnt     += mux_sel.dat_sel;
            csel_cnt    += mux_sel.checksum_select;
            init_rd_cnt += cbuf_ctrl.init_rd_addr;
            ben_cnt     += cntr_ctrl.burst_cntr_en;
        end
    end

    // a fill spans FILL_INIT1 (header select) until sm_idle comes back
    always @(negedge clk) begin
        if (track_enabled) begin
            if (mux_sel.fill_hdr_sel) begin
                in_fill = 1'b1;
            end else if (status.sm_idle) begin
                in_fill = 1'b0;
            end
            compare_bit("acq_enabled", in_fill, status.acq_enabled);
        end
    end

    // only called right after a rising edge
    task automatic clear_counts();
        valid_cnt   = 0;
        addr_cnt    = 0;
        latch_cnt   = 0;
        inc_cnt     = 0;
        upd_cnt     = 0;
        trig_rd_cnt = 0;
        fill_cnt    = 0;
        binit_cnt   = 0;
        dummy_cnt   = 0;
        pulse_cnt   = 0;
        hdr_cnt     = 0;
        wfm_cnt     = 0;
        dat_cnt     = 0;
        csel_cnt    = 0;
        init_rd_cnt = 0;
        ben_cnt     = 0;
    endtask

    // arm the trigger, queue an address and check the header latency
    task automatic start_fill(input int bursts);
        int waited;
        n_bursts = bursts;
        ddr3_wait_cycles = 5 + int'($urandom % 26);
        @(posedge clk);
        acq_trig <= 1'b1;
        // out of IDLE means watching the trigger fifo
        @(negedge clk);
        while (status.sm_idle) @(negedge clk);
        @(posedge clk);
        clear_counts();
        trig_fifo_empty <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!adc_acq_out_valid && waited < 10) begin
            waited++;
            @(negedge clk);
        end
        compare_count("first valid latency", 3, waited);
        // address popped so the fifo runs empty again
        while (!cbuf_ctrl.trig_addr_rd_en) @(negedge clk);
        @(posedge clk);
        trig_fifo_empty <= 1'b1;
    endtask

    task automatic end_fill();
        @(negedge clk);
        while (!status.acq_done) @(negedge clk);
        repeat (4) @(posedge clk);
        acq_trig <= 1'b0;
        @(negedge clk);
        while (!status.sm_idle) @(negedge clk);
    endtask

    task automatic verify_reset_state();
        @(negedge clk);
        compare_bit("sm_idle", 1'b1, status.sm_idle);
        compare_bit("acq_enabled", 1'b0, status.acq_enabled);
        compare_bit("acq_done", 1'b0, status.acq_done);
        compare_bit("mux_sel", 1'b0, |mux_sel);
        compare_bit("cbuf_ctrl", 1'b0, |cbuf_ctrl);
        compare_bit("cntr_ctrl", 1'b0, |cntr_ctrl);
        compare_bit("adc_acq_out_valid", 1'b0, adc_acq_out_valid);
        compare_bit("trig_pulse", 1'b0, trig_pulse);
    endtask

    task automatic toggle_trig(input int times);
        repeat (times) begin
            @(posedge clk);
            acq_trig <= 1'b1;
            repeat (8) @(posedge clk);
            acq_trig <= 1'b0;
            repeat (8) @(posedge clk);
        end
    endtask

    task automatic mode_and_trigger_decode();
        int v;
        @(posedge clk);
        clear_counts();
        // edges are ignored while the channel is not armed
        toggle_trig(3);
        compare_count("trig_pulse", 0, pulse_cnt);
        for (v = 1; v <= 3; v++) begin
            @(posedge clk);
            {acq_enable1, acq_enable0} <= v[1:0];
            repeat (5) @(posedge clk);
            @(negedge clk);
            compare_fill_type("fill_type", adc_acq_pkg::fill_type_t'(v), fill_type);
        end
        @(posedge clk);
        clear_counts();
        toggle_trig(3);
        compare_count("trig_pulse", 3, pulse_cnt);
    endtask

    task automatic count_fill_pulses(input int n);
        start_fill(n);
        end_fill();
        @(posedge clk);
        compare_count("adc_acq_out_valid", n + 3, valid_cnt);
        compare_count("address_cntr_en", n + 3, addr_cnt);
        compare_count("latch_dat", 4 * n + 2, latch_cnt);
        compare_count("inc_rd_addr", 4 * n + 1, inc_cnt);
        compare_count("checksum_update", n, upd_cnt);
        compare_count("trig_addr_rd_en", 1, trig_rd_cnt);
        compare_count("fill_cntr_en", 1, fill_cnt);
        compare_count("burst_cntr_init", 1, binit_cnt);
        compare_count("fill_hdr_sel", 1, hdr_cnt);
        compare_count("wfm_hdr_sel", 1, wfm_cnt);
        // RUN3 of every burst plus WAVEFORM_TST2
        compare_count("dat_sel", n + 1, dat_cnt);
        compare_count("checksum_select", 1, csel_cnt);
        compare_count("init_rd_addr", 1, init_rd_cnt);
        compare_count("burst_cntr_en", n, ben_cnt);
    endtask

    task automatic ddr3_done_wait();
        int i;
        int held;
        start_fill(1 + int'($urandom % 8));
        @(negedge clk);
        while (!ddr3_wr_done) begin
            compare_bit("acq_done", 1'b0, status.acq_done);
            @(negedge clk);
        end
        // done has to cross the synchronizer first
        for (i = 0; i < DONE_LATENCY; i++) begin
            compare_bit("acq_done", 1'b0, status.acq_done);
            @(negedge clk);
        end
        compare_bit("acq_done", 1'b1, status.acq_done);
        // DONE holds while the trigger is held
        repeat (10) begin
            @(negedge clk);
            compare_bit("acq_done", 1'b1, status.acq_done);
        end
        @(posedge clk);
        acq_trig <= 1'b0;
        held = 0;
        @(negedge clk);
        while (!status.sm_idle && held < 20) begin
            held++;
            @(negedge clk);
        end
        if (!status.sm_idle) begin
            note_failure("sm_idle did not return within 20 cycles after the trigger fell");
        end
    endtask

    task automatic dummy_reset_per_fill(input logic mode);
        @(posedge clk);
        dummy_dat_reset_mode <= mode;
        start_fill(1 + int'($urandom % 8));
        end_fill();
        @(posedge clk);
        compare_count("dummy_dat_reset", mode ? 1 : 0, dummy_cnt);
    endtask

    task automatic acq_enabled_window();
        @(posedge clk);
        track_enabled = 1'b1;
        start_fill(2);
        end_fill();
        @(posedge clk);
        track_enabled = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hedf3eb6f));
        adc_acq_full_reset   = 1'b1;
        acq_enable0          = 1'b0;
        acq_enable1          = 1'b0;
        acq_trig             = 1'b0;
        trig_fifo_empty      = 1'b1;
        burst_cntr_zero      = 1'b0;
        ddr3_wr_done         = 1'b0;
        dummy_dat_reset_mode = 1'b0;
        clear_counts();
        repeat (4) @(posedge clk);
        adc_acq_full_reset <= 1'b0;

        verify_reset_state();
        // leaves both enables set so fills use fill type 3
        mode_and_trigger_decode();
        count_fill_pulses(1);
        count_fill_pulses(8);
        repeat (2) count_fill_pulses(1 + int'($urandom % 8));
        ddr3_done_wait();
        dummy_reset_per_fill(1'b1);
        dummy_reset_per_fill(1'b0);
        acq_enabled_window();

        print_error_counts();
        if (error_total() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verif
hw/adc_acq_pkg.sv
hw/acq_input_sync.sv
hw/acq_fsm.sv
hw/acq_strobe_gen.sv
hw/adc_acq_ctrl.sv
verif/adc_acq_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: adc_acq_ctrl

sources:
  - hw/adc_acq_pkg.sv
  - hw/acq_input_sync.sv
  - hw/acq_fsm.sv
  - hw/acq_strobe_gen.sv
  - hw/adc_acq_ctrl.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/adc_acq_ctrl_tb.sv
